/* logic/ldpc_dec_cnode_update.sv */
//------------------------------
// check-node update stage
// builds one check-to-variable message per column,
// single output register with valid/ready hold
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldpc_dec_cnode_update
  import ldpc_dec_types_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  sort_if.user     sort,
  rowbuf_if.update rbuf,
  output logic     cn_valid,
  output logic     cn_sop,
  output logic     cn_eop,
  output col_t     cn_col,
  output node_t    cn_msg,
  input  logic     cn_ready
);

  mag_t  msg_mag;
  logic  msg_sign;
  node_t msg;
  logic  take;

  // free slot or slot draining this cycle
  assign rbuf.upd_ready = ~cn_valid | cn_ready;
  assign take           = rbuf.upd_val & rbuf.upd_ready;

  // min1 column gets min2, all others min1
  assign msg_mag  = (rbuf.rd_col == sort.res.min1_col) ? sort.res.min2 : sort.res.min1;
  // exclude own sign from product
  assign msg_sign = sort.res.prod_sign ^ rbuf.rd_sign;
  assign msg      = msg_sign ? -node_t'({1'b0, msg_mag}) : node_t'({1'b0, msg_mag});

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cn_valid <= 1'b0;
    end else if (take) begin
      cn_valid <= 1'b1;
    end else if (cn_ready) begin
      cn_valid <= 1'b0;
    end
  end

  // data holds until the next handover
  always_ff @(posedge iclk) begin
    if (take) begin
      cn_col <= rbuf.rd_col;
      cn_msg <= msg;
      cn_sop <= (rbuf.rd_col == '0);
      cn_eop <= (rbuf.rd_col == sort.num_m1);
    end
  end

endmodule

`default_nettype wire

/* logic/ldpc_dec_cnu.sv */
//------------------------------
// ldpc check-node unit, top level
// serial min-sum check node, one row in flight
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldpc_dec_cnu
  import ldpc_dec_const_pkg::*, ldpc_dec_types_pkg::*;
#(
  parameter int pNORM_FACTOR = 6
) (
  input  logic  iclk,
  input  logic  ireset,
  input  logic  start,
  input  logic  vn_valid,
  output logic  vn_ready,
  input  logic  vn_sop,
  input  logic  vn_eop,
  input  logic  vn_mask,
  input  node_t vn_llr,
  output logic  cn_valid,
  input  logic  cn_ready,
  output logic  cn_sop,
  output logic  cn_eop,
  output col_t  cn_col,
  output node_t cn_msg,
  output logic  decfail
);

  logic beat_val;

  sort_if   sort_bus ();
  rowbuf_if rowbuf_bus ();

  // sort engine sees accepted beats only
  assign beat_val = vn_valid & vn_ready;
  // masked column stores sign 0
  assign rowbuf_bus.wr_sign = vn_llr[NODE_W-1] & ~vn_mask;

  ldpc_dec_ctrl i_ctrl (
    .iclk     (iclk),
    .ireset   (ireset),
    .vn_valid (vn_valid),
    .vn_sop   (vn_sop),
    .vn_eop   (vn_eop),
    .vn_ready (vn_ready),
    .sort     (sort_bus),
    .rbuf     (rowbuf_bus)
  );

  ldpc_dec_sort_engine #(
    .pNORM_FACTOR (pNORM_FACTOR)
  ) i_sort_engine (
    .iclk     (iclk),
    .ireset   (ireset),
    .start    (start),
    .beat_val (beat_val),
    .sop      (vn_sop),
    .eop      (vn_eop),
    .mask     (vn_mask),
    .llr      (vn_llr),
    .sort     (sort_bus),
    .decfail  (decfail)
  );

  ldpc_dec_row_buffer i_row_buffer (
    .iclk (iclk),
    .rbuf (rowbuf_bus)
  );

  ldpc_dec_cnode_update i_cnode_update (
    .iclk     (iclk),
    .ireset   (ireset),
    .sort     (sort_bus),
    .rbuf     (rowbuf_bus),
    .cn_valid (cn_valid),
    .cn_sop   (cn_sop),
    .cn_eop   (cn_eop),
    .cn_col   (cn_col),
    .cn_msg   (cn_msg),
    .cn_ready (cn_ready)
  );

endmodule

`default_nettype wire

/* logic/ldpc_dec_const_pkg.sv */
//------------------------------
// ldpc decoder constants
// datapath widths and row limits
//------------------------------
`default_nettype none

package ldpc_dec_const_pkg;

  // llr width incl sign bit
  localparam int NODE_W  = 5;
  // magnitude after sign strip
  localparam int MAG_W   = NODE_W - 1;
  // largest row weight
  localparam int MAX_COL = 8;
  // column index width, fits MAX_COL
  localparam int COL_W   = 3;

endpackage

`default_nettype wire

/* logic/ldpc_dec_ctrl.sv */
//------------------------------
// check-node controller
// load, sort wait and emit sequencing,
// write and read column counters
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldpc_dec_ctrl
  import ldpc_dec_types_pkg::*;
(
  input  logic   iclk,
  input  logic   ireset,
  input  logic   vn_valid,
  input  logic   vn_sop,
  input  logic   vn_eop,
  output logic   vn_ready,
  sort_if.user   sort,
  rowbuf_if.ctrl rbuf
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  col_t        wr_cnt;
  col_t        rd_cnt;
  logic        beat;
  logic        handover;
  logic        emit_last;
  logic        leave_emit;

  assign beat       = vn_valid & vn_ready;
  assign handover   = rbuf.upd_val & rbuf.upd_ready;
  // eop beat gone or leaving on this edge
  assign leave_emit = (state == EMIT) & emit_last & rbuf.upd_ready;

  //------------------------------
  // next state
  //------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (beat && vn_eop) begin
          state_nxt = SORT;
        end else if (beat && vn_sop) begin
          state_nxt = LOAD;
        end
      end
      LOAD: begin
        if (beat && vn_eop) begin
          state_nxt = SORT;
        end
      end
      SORT: begin
        // result lands on the same edge
        if (sort.b1_pre_val) begin
          state_nxt = EMIT;
        end
      end
      EMIT: begin
        if (leave_emit) begin
          state_nxt = LOAD;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  //------------------------------
  // state, ready and counters
  //------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= IDLE;
      vn_ready  <= 1'b0;
      wr_cnt    <= '0;
      rd_cnt    <= '0;
      emit_last <= 1'b0;
    end else begin
      state    <= state_nxt;
      // ready follows the state it will be in
      vn_ready <= (state_nxt == IDLE) || (state_nxt == LOAD);
      if (beat) begin
        wr_cnt <= vn_sop ? col_t'(1) : wr_cnt + 1'b1;
      end
      if (leave_emit) begin
        rd_cnt    <= '0;
        emit_last <= 1'b0;
      end else if (handover) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == sort.num_m1) begin
          emit_last <= 1'b1;
        end
      end
    end
  end

  //------------------------------
  // row buffer and update handover
  //------------------------------
  assign rbuf.wr_en   = beat;
  assign rbuf.wr_col  = vn_sop ? '0 : wr_cnt;
  assign rbuf.rd_col  = rd_cnt;
  // emit starts with res_val and runs until the last column is out
  assign rbuf.upd_val = (state == EMIT) & ~emit_last;

endmodule

`default_nettype wire

/* logic/ldpc_dec_ifs.sv */
//------------------------------
// ldpc decoder internal buses
// sort result bus and row buffer bus
//------------------------------
`timescale 1ns/1ns
`default_nettype none

// sort engine result, one pulse per row
interface sort_if
  import ldpc_dec_types_pkg::*;
();
  // one cycle ahead of res_val
  logic    b1_pre_val;
  logic    res_val;
  vn_min_t res;
  // last column index of the row
  col_t    num_m1;

  modport sorter (output b1_pre_val, res_val, res, num_m1);
  modport user   (input  b1_pre_val, res_val, res, num_m1);
endinterface

// sign store access and update handover
interface rowbuf_if
  import ldpc_dec_types_pkg::*;
();
  logic wr_en;
  col_t wr_col;
  logic wr_sign;
  col_t rd_col;
  logic rd_sign;
  // column handover to update stage
  logic upd_val;
  logic upd_ready;

  modport ctrl   (output wr_en, wr_col, rd_col, upd_val, input upd_ready);
  modport store  (input wr_en, wr_col, wr_sign, rd_col, output rd_sign);
  modport update (input rd_col, rd_sign, upd_val, output upd_ready);
endinterface

`default_nettype wire

/* logic/ldpc_dec_row_buffer.sv */
//------------------------------
// check-node row buffer
// one sign bit per column of the current row
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldpc_dec_row_buffer
  import ldpc_dec_const_pkg::*;
(
  input  logic    iclk,
  rowbuf_if.store rbuf
);

  // sign of each column, masked columns hold 0
  logic [MAX_COL-1:0] sign_q;

  //------------------------------
  // write port, load phase
  //------------------------------
  always_ff @(posedge iclk) begin
    if (rbuf.wr_en) begin
      sign_q[rbuf.wr_col] <= rbuf.wr_sign;
    end
  end

  //------------------------------
  // read port, emit phase
  //------------------------------
  // async read, same cycle as the handover
  assign rbuf.rd_sign = sign_q[rbuf.rd_col];

endmodule

`default_nettype wire

/* logic/ldpc_dec_sort_engine.sv */
//------------------------------
// check-node sort engine
// serial min1/min2/sign search over one row,
// normalized result and frame decode-fail flag
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldpc_dec_sort_engine
  import ldpc_dec_const_pkg::*, ldpc_dec_types_pkg::*;
#(
  parameter int pNORM_FACTOR = 6
) (
  input  logic   iclk,
  input  logic   ireset,
  input  logic   start,
  input  logic   beat_val,
  input  logic   sop,
  input  logic   eop,
  input  logic   mask,
  input  node_t  llr,
  sort_if.sorter sort,
  output logic   decfail
);

  // m*F+4 needs 3 extra bits
  localparam int NORM_W = MAG_W + 3;

  logic [NODE_W-1:0] llr_abs;
  mag_t              in_mag;
  logic              s0_val;
  logic              s0_done;
  logic              s0_sop;
  logic              s0_sign;
  mag_t              s0_mag;
  col_t              s0_col;
  vn_min_t           acc;
  col_t              acc_num_m1;
  logic              s1_done;
  logic              lt_min1;
  logic              lt_min2;
  vn_min_t           s2_res;
  col_t              s2_num_m1;
  logic              s2_done;
  logic              s2_fail;

  // floor((m*F + 4) / 8), F in eighths
  function automatic mag_t normalize(input mag_t m);
    logic [NORM_W-1:0] prod;
    prod = NORM_W'(m) * NORM_W'(pNORM_FACTOR) + NORM_W'(4);
    // F = 0 leaves the magnitude alone
    if (pNORM_FACTOR == 0) begin
      return m;
    end
    return prod[NORM_W-1:3];
  endfunction

  //------------------------------
  // stage 0, abs and sign
  //------------------------------
  assign llr_abs = llr[NODE_W-1] ? NODE_W'(-llr) : NODE_W'(llr);
  // most negative llr saturates
  assign in_mag  = llr_abs[NODE_W-1] ? '1 : llr_abs[MAG_W-1:0];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s0_val  <= 1'b0;
      s0_done <= 1'b0;
      s0_col  <= '0;
    end else begin
      s0_val  <= beat_val;
      s0_done <= beat_val & eop;
      if (beat_val) begin
        s0_col <= sop ? '0 : s0_col + 1'b1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (beat_val) begin
      s0_sop  <= sop;
      // masked column is max magnitude, positive
      s0_sign <= mask ? 1'b0 : llr[NODE_W-1];
      s0_mag  <= mask ? '1 : in_mag;
    end
  end

  //------------------------------
  // stage 1, serial sort
  //------------------------------
  // strict compare keeps first tie as min1
  assign lt_min1 = s0_mag < acc.min1;
  assign lt_min2 = s0_mag < acc.min2;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_done <= 1'b0;
    end else begin
      s1_done <= s0_done;
    end
  end

  always_ff @(posedge iclk) begin
    if (s0_val) begin
      acc_num_m1 <= s0_col;
      if (s0_sop) begin
        acc.prod_sign <= s0_sign;
        acc.min1      <= s0_mag;
        acc.min2      <= '1;
        acc.min1_col  <= s0_col;
      end else begin
        acc.prod_sign <= acc.prod_sign ^ s0_sign;
        if (lt_min1) begin
          acc.min1     <= s0_mag;
          acc.min1_col <= s0_col;
        end
        // old min1 drops to min2 on a new minimum
        if (lt_min2) begin
          acc.min2 <= lt_min1 ? acc.min1 : s0_mag;
        end
      end
    end
  end

  //------------------------------
  // stage 2, normalize and fail check
  //------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s2_done <= 1'b0;
    end else begin
      s2_done <= s1_done;
    end
  end

  always_ff @(posedge iclk) begin
    if (s1_done) begin
      s2_res.prod_sign <= acc.prod_sign;
      s2_res.min1      <= normalize(acc.min1);
      s2_res.min2      <= normalize(acc.min2);
      s2_res.min1_col  <= acc.min1_col;
      s2_num_m1        <= acc_num_m1;
      // unsatisfied parity or raw min1 of 0..1
      s2_fail          <= acc.prod_sign | (acc.min1[MAG_W-1:1] == '0);
    end
  end

  // look-ahead for the controller
  assign sort.b1_pre_val = s2_done;

  //------------------------------
  // stage 3, result and frame flag
  //------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sort.res_val <= 1'b0;
      decfail      <= 1'b0;
    end else begin
      sort.res_val <= s2_done;
      if (start) begin
        decfail <= 1'b0;
      end else if (s2_done) begin
        decfail <= decfail | s2_fail;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (s2_done) begin
      sort.res    <= s2_res;
      sort.num_m1 <= s2_num_m1;
    end
  end

endmodule

`default_nettype wire

/* logic/ldpc_dec_types_pkg.sv */
//------------------------------
// ldpc decoder shared types
// llr, magnitude and column types, sort result struct,
// controller states
//------------------------------
`default_nettype none

package ldpc_dec_types_pkg;
  import ldpc_dec_const_pkg::*;

  // signed variable-node llr
  typedef logic signed [NODE_W-1:0] node_t;

  // unsigned magnitude
  typedef logic [MAG_W-1:0] mag_t;

  // column index in row
  typedef logic [COL_W-1:0] col_t;

  // per-row min-sum result
  typedef struct packed {
    logic prod_sign;
    mag_t min1;
    mag_t min2;
    col_t min1_col;
  } vn_min_t;

  // check-node controller
  typedef enum logic [1:0] {IDLE, LOAD, SORT, EMIT} ctrl_state_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the check-node unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module ldpc_dec_cnu_tb -f verilog.f -Mdir obj_dir -o sim_cnu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_cnu +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
  exit 0
fi
exit 1

/* verif/ldpc_dec_cnu_asserts.sv */
//------------------------------
// check-node controller assertions
// input ready, output stall and result pulse timing
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldpc_dec_cnu_asserts
  import ldpc_dec_types_pkg::*;
(
  input logic        iclk,
  input logic        ireset,
  input ctrl_state_t state,
  input logic        vn_ready,
  input logic        b1_pre_val,
  input logic        res_val,
  input logic        upd_ready,
  input col_t        rd_col
);

  // count of failed assertions
  int fail_count = 0;

  // input closed while sorting or emitting
  a_ready_state: assert property (@(posedge iclk) disable iff (ireset)
      !(state inside {IDLE, LOAD}) |-> !vn_ready)
    else begin
      fail_count++;
      $error("vn_ready high outside idle and load");
    end

  // presented column holds while the output slot is stalled
  a_stall_hold: assert property (@(posedge iclk) disable iff (ireset)
      !upd_ready |=> $stable(rd_col))
    else begin
      fail_count++;
      $error("read column moved while the output was stalled");
    end

  // res_val exactly one cycle after the look-ahead
  a_pre_to_res: assert property (@(posedge iclk) disable iff (ireset)
      b1_pre_val |=> res_val)
    else begin
      fail_count++;
      $error("res_val missing after b1_pre_val");
    end

  a_res_from_pre: assert property (@(posedge iclk) disable iff (ireset)
      res_val |-> $past(b1_pre_val))
    else begin
      fail_count++;
      $error("res_val without b1_pre_val one cycle before");
    end

endmodule

bind ldpc_dec_ctrl ldpc_dec_cnu_asserts i_ctrl_asserts (
  .iclk       (iclk),
  .ireset     (ireset),
  .state      (state),
  .vn_ready   (vn_ready),
  .b1_pre_val (sort.b1_pre_val),
  .res_val    (sort.res_val),
  .upd_ready  (rbuf.upd_ready),
  .rd_col     (rbuf.rd_col)
);

`default_nettype wire

/* verif/ldpc_dec_cnu_tb.sv */
//------------------------------
// check-node unit testbench
// row table, min-sum reference model,
// random input gaps and output stalls
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldpc_dec_cnu_tb
  import ldpc_dec_types_pkg::*;
();

  localparam int NUM_ROWS = 12;
  localparam int NORM_F   = 6;
  localparam int TMO      = 200;

  logic  iclk;
  logic  ireset;
  logic  start;
  logic  vn_valid;
  logic  vn_ready;
  logic  vn_sop;
  logic  vn_eop;
  logic  vn_mask;
  node_t vn_llr;
  logic  cn_valid;
  logic  cn_ready;
  logic  cn_sop;
  logic  cn_eop;
  col_t  cn_col;
  node_t cn_msg;
  logic  decfail;

  //------------------------------
  // row table
  //------------------------------
  // new frame before the row
  bit row_start [NUM_ROWS] = '{1, 0, 0, 1, 0, 1, 1, 0, 1, 0, 1, 0};
  // columns in the row
  int row_ncol [NUM_ROWS] = '{4, 6, 8, 5, 3, 4, 4, 2, 3, 1, 8, 3};
  // bit c set masks column c
  logic [7:0] row_mask [NUM_ROWS] = '{8'h00, 8'h00, 8'ha4, 8'h00, 8'h00, 8'h00,
                                      8'h00, 8'h00, 8'h00, 8'h00, 8'h80, 8'h06};
  // llr per column with unused columns at 0
  int row_llr [NUM_ROWS][8] = '{
    '{7, 3, 9, 5, 0, 0, 0, 0},
    '{4, 4, 4, 4, 4, 4, 0, 0},
    '{9, 5, -1, 7, 4, -3, 8, -2},
    '{6, -2, 8, 10, 4, 0, 0, 0},
    '{5, 6, 7, 0, 0, 0, 0, 0},
    '{-3, -5, 7, -6, 0, 0, 0, 0},
    '{-3, -5, 7, 6, 0, 0, 0, 0},
    '{12, 11, 0, 0, 0, 0, 0, 0},
    '{1, 9, 12, 0, 0, 0, 0, 0},
    '{10, 0, 0, 0, 0, 0, 0, 0},
    '{3, -4, 0, 5, 6, -7, 2, -9},
    '{8, -2, -3, 0, 0, 0, 0, 0}
  };

  // model results
  node_t       exp_msg [8];
  logic        row_fail;
  logic        frame_fail;
  int unsigned lcg_state;
  int          checks;
  int          errors;

  ldpc_dec_cnu #(
    .pNORM_FACTOR (NORM_F)
  ) i_ldpc_dec_cnu (
    .iclk     (iclk),
    .ireset   (ireset),
    .start    (start),
    .vn_valid (vn_valid),
    .vn_ready (vn_ready),
    .vn_sop   (vn_sop),
    .vn_eop   (vn_eop),
    .vn_mask  (vn_mask),
    .vn_llr   (vn_llr),
    .cn_valid (cn_valid),
    .cn_ready (cn_ready),
    .cn_sop   (cn_sop),
    .cn_eop   (cn_eop),
    .cn_col   (cn_col),
    .cn_msg   (cn_msg),
    .decfail  (decfail)
  );

  initial begin
    iclk = 1'b0;
    forever #50 iclk = ~iclk;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic check_hex(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    errors += i_ldpc_dec_cnu.i_ctrl.i_ctrl_asserts.fail_count;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    errors++;
    $display("timeout while %s", what);
    finish_run();
  endtask

  //------------------------------
  // reference model
  //------------------------------
  task automatic model_row(input int r);
    int   mag [8];
    logic sgn [8];
    int   v;
    int   m;
    int   min1;
    int   min1_col;
    int   min2;
    logic prod;
    prod     = 1'b0;
    min1     = 16;
    min1_col = 0;
    min2     = 15;
    for (int c = 0; c < row_ncol[r]; c++) begin
      v      = row_llr[r][c];
      mag[c] = (v < 0) ? -v : v;
      sgn[c] = (v < 0);
      // masked column is max magnitude and positive
      if (row_mask[r][c]) begin
        mag[c] = 15;
        sgn[c] = 1'b0;
      end else if (mag[c] > 15) begin
        mag[c] = 15;
      end
      prod = prod ^ sgn[c];
      // first column reaching the minimum wins
      if (mag[c] < min1) begin
        min1     = mag[c];
        min1_col = c;
      end
    end
    // smallest among the other columns
    for (int c = 0; c < row_ncol[r]; c++) begin
      if (c != min1_col && mag[c] < min2) begin
        min2 = mag[c];
      end
    end
    for (int c = 0; c < row_ncol[r]; c++) begin
      m          = (c == min1_col) ? min2 : min1;
      m          = (m * NORM_F + 4) / 8;
      exp_msg[c] = node_t'((prod ^ sgn[c]) ? -m : m);
    end
    row_fail = prod | (min1 <= 1);
  endtask

  //------------------------------
  // input and output streams
  //------------------------------
  task automatic send_row(input int r);
    int tmo;
    for (int c = 0; c < row_ncol[r]; c++) begin
      // random idle cycle on the input
      if (next_rand() % 4 == 0) begin
        vn_valid <= 1'b0;
        @(posedge iclk);
      end
      vn_valid <= 1'b1;
      vn_sop   <= (c == 0);
      vn_eop   <= (c == row_ncol[r] - 1);
      vn_mask  <= row_mask[r][c];
      vn_llr   <= node_t'(row_llr[r][c]);
      tmo = 0;
      @(negedge iclk);
      while (!vn_ready) begin
        tmo++;
        if (tmo > TMO) begin
          give_up("waiting for vn_ready");
        end
        @(negedge iclk);
      end
      @(posedge iclk);
    end
    vn_valid <= 1'b0;
  endtask

  task automatic recv_row(input int r);
    int    tmo;
    int    edges;
    logic  held;
    node_t held_msg;
    col_t  held_col;
    // edges from the eop beat to the first message
    edges = 0;
    @(negedge iclk);
    while (!cn_valid) begin
      // input stays closed while the row is sorted
      check_hex("vn_ready", 8'(vn_ready), 8'h00);
      @(posedge iclk);
      edges++;
      if (edges > TMO) begin
        give_up("waiting for the first cn_valid");
      end
      @(negedge iclk);
    end
    check_hex("first cn_valid latency", 8'(edges), 8'd4);
    held = 1'b0;
    for (int c = 0; c < row_ncol[r]; c++) begin
      tmo = 0;
      while (!(cn_valid && cn_ready)) begin
        // stalled beat keeps its data
        if (held) begin
          check_hex("cn_valid in stall", 8'(cn_valid), 8'h01);
          check_hex("cn_msg in stall", 8'(cn_msg), 8'(held_msg));
          check_hex("cn_col in stall", 8'(cn_col), 8'(held_col));
        end
        held     = cn_valid;
        held_msg = cn_msg;
        held_col = cn_col;
        @(posedge iclk);
        cn_ready <= (next_rand() % 3) != 0;
        tmo++;
        if (tmo > TMO) begin
          give_up("waiting for an output beat");
        end
        @(negedge iclk);
      end
      check_hex($sformatf("cn_col beat %0d", c), 8'(cn_col), 8'(c));
      check_hex($sformatf("cn_sop col %0d", c), 8'(cn_sop), 8'(c == 0));
      check_hex($sformatf("cn_eop col %0d", c), 8'(cn_eop), 8'(c == row_ncol[r] - 1));
      check_hex($sformatf("cn_msg col %0d", c), 8'(cn_msg), 8'(exp_msg[c]));
      held = 1'b0;
      @(posedge iclk);
      // ready high again before the next row
      cn_ready <= (c == row_ncol[r] - 1) ? 1'b1 : ((next_rand() % 3) != 0);
      if (c != row_ncol[r] - 1) begin
        @(negedge iclk);
      end
    end
  endtask

  //------------------------------
  // main sequence
  //------------------------------
  initial begin
    lcg_state  = 32'd24020;
    checks     = 0;
    errors     = 0;
    frame_fail = 1'b0;
    ireset     = 1'b1;
    start      = 1'b0;
    vn_valid   = 1'b0;
    vn_sop     = 1'b0;
    vn_eop     = 1'b0;
    vn_mask    = 1'b0;
    vn_llr     = '0;
    cn_ready   = 1'b1;
    repeat (5) @(posedge iclk);
    ireset <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (row_start[r]) begin
        start <= 1'b1;
        @(posedge iclk);
        start <= 1'b0;
        @(negedge iclk);
        check_hex("decfail after start", 8'(decfail), 8'h00);
        @(posedge iclk);
        frame_fail = 1'b0;
      end
      model_row(r);
      frame_fail = frame_fail | row_fail;
      send_row(r);
      recv_row(r);
      @(negedge iclk);
      check_hex($sformatf("decfail row %0d", r), 8'(decfail), 8'(frame_fail));
      check_hex("cn_valid after eop", 8'(cn_valid), 8'h00);
      @(posedge iclk);
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/ldpc_dec_const_pkg.sv
logic/ldpc_dec_types_pkg.sv
logic/ldpc_dec_ifs.sv
logic/ldpc_dec_sort_engine.sv
logic/ldpc_dec_row_buffer.sv
logic/ldpc_dec_cnode_update.sv
logic/ldpc_dec_ctrl.sv
logic/ldpc_dec_cnu.sv
verif/ldpc_dec_cnu_asserts.sv
verif/ldpc_dec_cnu_tb.sv
